// ==== design/led_cube_pkg.sv ====
`default_nettype none

package led_cube_pkg;

    localparam int num_drivers    = 30;
    localparam int led_per_driver = 16;
    localparam int num_columns    = 9;
    localparam int num_channels   = 3;

    // Channel order on the driver lanes
    typedef enum logic [1:0] {
        blue  = 2'd0,
        green = 2'd1,
        red   = 2'd2
    } color_t;

    // Colour rotation applied to the stripe image
    typedef enum logic [1:0] {
        rgb = 2'd0,
        brg = 2'd1,
        gbr = 2'd2
    } pattern_t;

    // Position of the slot currently on the lanes
    typedef struct packed {
        logic [3:0] column;
        logic [3:0] bit_pos;
        logic [3:0] led;
        color_t     channel;
    } slot_pos_t;

    // Pure RGB565 colours, indexed by color_t
    localparam logic [num_channels-1:0][15:0] color_word = '{
        16'b00000_000000_11111,
        16'b00000_111111_00000,
        16'b11111_000000_00000
    };

    // Lowest sent bit of each RGB565 field, indexed by color_t
    localparam logic [num_channels-1:0][3:0] color_base = '{4'd0, 4'd6, 4'd11};

    // LED to voxel row order, group 0 is drivers 20 to 29
    localparam logic [3:0] led_order_g0 [led_per_driver] = '{
        4'd6, 4'd7, 4'd9, 4'd8, 4'd10, 4'd11, 4'd13, 4'd12,
        4'd14, 4'd15, 4'd1, 4'd0, 4'd2, 4'd3, 4'd5, 4'd4
    };

    // Group 1 is drivers 0 to 19
    localparam logic [3:0] led_order_g1 [led_per_driver] = '{
        4'd2, 4'd3, 4'd5, 4'd4, 4'd6, 4'd7, 4'd9, 4'd8,
        4'd10, 4'd11, 4'd13, 4'd12, 4'd14, 4'd15, 4'd1, 4'd0
    };

endpackage

`default_nettype wire

// ==== design/pattern_select.sv ====
`default_nettype none

module pattern_select (
    input  wire logic             clk_33,
    input  wire logic             nrst,
    input  wire logic             button,
    input  wire logic             column_start,
    output led_cube_pkg::pattern_t pattern
);

    logic                   prev_button;
    logic                   pending;
    led_cube_pkg::pattern_t pattern_q;
    led_cube_pkg::pattern_t pattern_rot;

    // Next colour rotation in the cycle rgb, brg, gbr
    always_comb begin
        case (pattern_q)
            led_cube_pkg::rgb: pattern_rot = led_cube_pkg::brg;
            led_cube_pkg::brg: pattern_rot = led_cube_pkg::gbr;
            default:           pattern_rot = led_cube_pkg::rgb;
        endcase
    end

    // New pattern is visible already for the first slot of the column
    assign pattern = (column_start && pending) ? pattern_rot : pattern_q;

    always_ff @(posedge clk_33 or negedge nrst) begin
        if (!nrst) begin
            prev_button <= 1'b0;
            pending     <= 1'b0;
            pattern_q   <= led_cube_pkg::rgb;
        end else begin
            prev_button <= button;
            pattern_q   <= pattern;
            // Edges in the same cycle as a column start wait for the next one
            if (button && !prev_button) begin
                pending <= 1'b1;
            end else if (column_start) begin
                pending <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/driver_sequencer.sv ====
`default_nettype none

module driver_sequencer #(
    parameter int POKER_MODE      = 9,
    parameter int BLANKING_CYCLES = 72
) (
    input  wire logic               clk_33,
    input  wire logic               nrst,
    output led_cube_pkg::slot_pos_t slot,
    output logic                    slot_valid,
    output logic                    column_start,
    output logic                    latch,
    output logic                    blank,
    output logic [3:0]              column
);

    localparam int         blank_w  = $clog2(BLANKING_CYCLES + 1);
    localparam logic [3:0] top_bit  = 4'(POKER_MODE - 1);
    localparam logic [3:0] top_led  = 4'(led_cube_pkg::led_per_driver - 1);
    localparam logic [3:0] last_col = 4'(led_cube_pkg::num_columns - 1);

    typedef enum logic {
        streaming,
        blanking
    } phase_t;

    phase_t                  phase;
    logic [blank_w-1:0]      blank_cnt;
    led_cube_pkg::slot_pos_t pos;
    logic                    last_slot;

    assign last_slot = (pos.channel == led_cube_pkg::red) && (pos.led == '0)
                       && (pos.bit_pos == '0);

    assign slot         = pos;
    assign slot_valid   = (phase == streaming);
    assign blank        = (phase == blanking);
    assign latch        = blank && (blank_cnt == blank_w'(BLANKING_CYCLES - 1));
    // Counters sit on the first slot whenever a column begins
    assign column_start = slot_valid && (pos.channel == led_cube_pkg::blue)
                          && (pos.led == top_led) && (pos.bit_pos == top_bit);

    // Phase control, blanking first after reset
    always_ff @(posedge clk_33 or negedge nrst) begin
        if (!nrst) begin
            phase     <= blanking;
            blank_cnt <= '0;
        end else begin
            case (phase)
                blanking: begin
                    if (latch) begin
                        phase     <= streaming;
                        blank_cnt <= '0;
                    end else begin
                        blank_cnt <= blank_cnt + 1'b1;
                    end
                end
                default: begin
                    if (last_slot) begin
                        phase <= blanking;
                    end
                end
            endcase
        end
    end

    // Nested slot counters: channel, then LED, then bit, then column
    always_ff @(posedge clk_33 or negedge nrst) begin
        if (!nrst) begin
            pos.column  <= '0;
            pos.bit_pos <= top_bit;
            pos.led     <= top_led;
            pos.channel <= led_cube_pkg::blue;
        end else if (phase == streaming) begin
            case (pos.channel)
                led_cube_pkg::blue:  pos.channel <= led_cube_pkg::green;
                led_cube_pkg::green: pos.channel <= led_cube_pkg::red;
                default:             pos.channel <= led_cube_pkg::blue;
            endcase
            if (pos.channel == led_cube_pkg::red) begin
                pos.led <= pos.led - 1'b1;
                if (pos.led == '0) begin
                    pos.led     <= top_led;
                    pos.bit_pos <= pos.bit_pos - 1'b1;
                    if (pos.bit_pos == '0) begin
                        pos.bit_pos <= top_bit;
                        pos.column  <= (pos.column == last_col) ? '0 : pos.column + 1'b1;
                    end
                end
            end
        end
    end

    // Shows the column whose data the latch has just captured
    always_ff @(posedge clk_33 or negedge nrst) begin
        if (!nrst) begin
            column <= last_col;
        end else if (latch) begin
            column <= (pos.column == '0) ? last_col : pos.column - 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== design/framebuffer_emulator.sv ====
`default_nettype none

module framebuffer_emulator #(
    parameter int POKER_MODE = 9
) (
    input  wire logic                              clk_33,
    input  wire logic                              nrst,
    input  wire led_cube_pkg::slot_pos_t           slot,
    input  wire logic                              slot_valid,
    input  wire led_cube_pkg::pattern_t            pattern,
    output logic [led_cube_pkg::num_drivers-1:0]   data
);

    // Five bit positions per colour are sent, the rest is padding
    localparam int field_bits = 5;
    localparam int pad_bits   = POKER_MODE - field_bits;
    // Drivers below this index belong to group 1
    localparam int g1_drivers = 20;

    logic [3:0]                           bit_addr;
    logic                                 in_field;
    logic [led_cube_pkg::num_drivers-1:0] voxel_bits;

    // Bit of the RGB565 word selected by channel and bit position
    assign bit_addr = led_cube_pkg::color_base[slot.channel] + 4'(int'(slot.bit_pos) - pad_bits);
    assign in_field = int'(slot.bit_pos) >= pad_bits;

    always_comb begin
        logic [3:0]           order;
        int                   row;
        led_cube_pkg::color_t voxel;

        for (int i = 0; i < led_cube_pkg::num_drivers; i++) begin
            if (i < g1_drivers) begin
                order = led_cube_pkg::led_order_g1[slot.led];
            end else begin
                order = led_cube_pkg::led_order_g0[slot.led];
            end

            // Stripe row of this driver for the current LED
            row = (i / 2) % 5 + 5 * (i / 10) + 5 * (int'(order) % 3);

            // Rotation shifts the stripe colours
            case ((row + int'(pattern)) % 3)
                0:       voxel = led_cube_pkg::red;
                1:       voxel = led_cube_pkg::blue;
                default: voxel = led_cube_pkg::green;
            endcase

            // A pure colour is zero outside its own field
            voxel_bits[i] = led_cube_pkg::color_word[voxel][bit_addr];
        end
    end

    always_ff @(posedge clk_33 or negedge nrst) begin
        if (!nrst) begin
            data <= '0;
        end else if (slot_valid && in_field) begin
            data <= voxel_bits;
        end else begin
            data <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== design/led_cube_top.sv ====
`default_nettype none

module led_cube_top #(
    parameter int POKER_MODE      = 9,
    parameter int BLANKING_CYCLES = 72
) (
    input  wire logic                            clk_33,
    input  wire logic                            nrst,
    input  wire logic                            button,
    output logic [led_cube_pkg::num_drivers-1:0] data,
    output logic                                 latch,
    output logic                                 blank,
    output logic [3:0]                           column
);

    led_cube_pkg::slot_pos_t slot;
    logic                    slot_valid;
    logic                    column_start;
    led_cube_pkg::pattern_t  pattern;

    driver_sequencer #(
        .POKER_MODE      (POKER_MODE),
        .BLANKING_CYCLES (BLANKING_CYCLES)
    ) u_sequencer (
        .clk_33       (clk_33),
        .nrst         (nrst),
        .slot         (slot),
        .slot_valid   (slot_valid),
        .column_start (column_start),
        .latch        (latch),
        .blank        (blank),
        .column       (column)
    );

    // Rotation changes only where a column begins
    pattern_select u_pattern (
        .clk_33       (clk_33),
        .nrst         (nrst),
        .button       (button),
        .column_start (column_start),
        .pattern      (pattern)
    );

    framebuffer_emulator #(
        .POKER_MODE (POKER_MODE)
    ) u_emulator (
        .clk_33     (clk_33),
        .nrst       (nrst),
        .slot       (slot),
        .slot_valid (slot_valid),
        .pattern    (pattern),
        .data       (data)
    );

endmodule

`default_nettype wire

// ==== verification/led_cube_asserts.sv ====
`default_nettype none

module led_cube_asserts (
    input wire logic                                 clk_33,
    input wire logic                                 nrst,
    input wire logic                                 latch,
    input wire logic                                 blank,
    input wire logic [led_cube_pkg::num_drivers-1:0] data
);

    latch_single_cycle: assert property (@(posedge clk_33) disable iff (!nrst)
        latch |=> !latch)
        else $error("latch stayed high for more than one cycle");

    // Latch marks the last blanking cycle
    latch_in_blanking: assert property (@(posedge clk_33) disable iff (!nrst)
        latch |-> blank ##1 !blank)
        else $error("latch not on the last blanking cycle");

    data_zero_after_blank: assert property (@(posedge clk_33) disable iff (!nrst)
        blank |=> (data == '0))
        else $error("data not zero in the cycle after a blanking cycle");

endmodule

bind led_cube_top led_cube_asserts u_asserts (
    .clk_33 (clk_33),
    .nrst   (nrst),
    .latch  (latch),
    .blank  (blank),
    .data   (data)
);

`default_nettype wire

// ==== verification/led_cube_tb.sv ====
`default_nettype none

module led_cube_tb;

    localparam int column_cycles = 504;
    localparam int blank_cycles  = 72;
    localparam int rec_words     = 5;
    localparam int max_records   = 32;

    logic                                 clk_33;
    logic                                 nrst;
    logic                                 button;
    logic [led_cube_pkg::num_drivers-1:0] data;
    logic                                 latch;
    logic                                 blank;
    logic [3:0]                           column;

    // Records of five words: kind, column, pattern, slot, data word
    logic [31:0] golden [rec_words*max_records];
    int          cyc            = 0;
    int          latch_count    = 0;
    int          col_exp        = led_cube_pkg::num_columns - 1;
    int          watchdog_limit = 0;

    led_cube_top uut (
        .clk_33 (clk_33),
        .nrst   (nrst),
        .button (button),
        .data   (data),
        .latch  (latch),
        .blank  (blank),
        .column (column)
    );

    initial begin
        clk_33 = 1'b0;
        forever #2 clk_33 = ~clk_33;
    end

    // Cycle 0 is the first cycle after reset release
    always @(posedge clk_33) begin
        if (!nrst) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at time %0t: %s is 0x%h, expected 0x%h",
                     $time, name, actual, expected);
            $display("CHECKS FAILED");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1, "Run stopped");
    endtask

    task automatic wait_for_cycle(input int target);
        if (cyc > target) begin
            stop_run("Golden records are not in time order");
        end
        while (cyc < target) @(negedge clk_33);
    endtask

    // One button pulse early in the blanking phase before column col
    task automatic press_button(input int col);
        int start;
        start = col * column_cycles + 2;
        while (cyc < start) @(negedge clk_33);
        if (cyc - col * column_cycles > 40) begin
            stop_run("Button press would fall outside the blanking phase");
        end
        repeat ($urandom_range(4, 1)) @(posedge clk_33);
        button <= 1'b1;
        @(posedge clk_33);
        button <= 1'b0;
    endtask

    // Phase, latch, column and blanking data, every cycle
    always @(negedge clk_33) begin
        if (nrst) begin
            check_value("blank", 32'(blank), 32'((cyc % column_cycles) < blank_cycles));
            check_value("latch", 32'(latch), 32'((cyc % column_cycles) == blank_cycles - 1));
            if ((cyc % column_cycles) <= blank_cycles) begin
                check_value("data", 32'(data), 32'd0);
            end
            check_value("column", 32'(column), 32'(col_exp));
            if (latch) begin
                // First latch has captured no column yet
                if (latch_count > 0) begin
                    col_exp = (col_exp + 1) % led_cube_pkg::num_columns;
                end
                latch_count = latch_count + 1;
            end
        end
    end

    initial begin
        wait (watchdog_limit > 0);
        #(watchdog_limit);
        stop_run("Watchdog expired before the run finished");
    end

    initial begin
        int r;
        int col;
        int target;
        int num_cols;

        nrst   = 1'b0;
        button = 1'b0;
        void'($urandom(32'h2f32_4a70));
        for (int i = 0; i < rec_words * max_records; i++) begin
            golden[i] = '0;
        end
        $readmemh("verification/led_cube_golden.txt", golden);

        r = 0;
        while (golden[r*rec_words] != 32'hf) begin
            if (golden[r*rec_words] != 32'h1 && golden[r*rec_words] != 32'h2) begin
                stop_run("Golden file holds an unknown record kind or lacks its end record");
            end
            r = r + 1;
            if (r == max_records) begin
                stop_run("Golden file holds too many records");
            end
        end
        num_cols       = int'(golden[r*rec_words + 1]);
        watchdog_limit = (num_cols + 2) * column_cycles * 4;

        repeat (3) @(posedge clk_33);
        nrst <= 1'b1;

        for (int n = 0; n < r; n++) begin
            col = int'(golden[n*rec_words + 1]);
            if (golden[n*rec_words] == 32'h1) begin
                press_button(col);
            end else begin
                // Word of slot s appears one cycle after the slot
                target = col * column_cycles + blank_cycles + 1 + int'(golden[n*rec_words + 3]);
                wait_for_cycle(target);
                check_value("data", 32'(data), golden[n*rec_words + 4]);
                check_value("pattern", 32'(uut.pattern), golden[n*rec_words + 2]);
            end
        end

        wait_for_cycle(num_cols * column_cycles + blank_cycles + 8);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/led_cube_golden.txt ====
// kind column pattern slot data, all hex; kind 1 is a press in the blanking before column,
// kind 2 checks the data word of slot in column, kind f ends with the number of columns
2 00 0 000 30c0c30c
2 00 0 001 03030c30
2 00 0 002 0c3c30c3
2 00 0 0fa 00000000
2 01 0 0be 30c0c30c
1 02 0 000 00000000
2 02 1 000 0c3c30c3
2 02 1 064 03030c30
2 03 1 0be 0c3c30c3
1 04 0 000 00000000
2 04 2 001 0c3c30c3
2 04 2 0ec 30c0c30c
1 06 0 000 00000000
1 06 0 000 00000000
1 06 0 000 00000000
2 06 0 00e 030c30c3
1 08 0 000 00000000
1 08 0 000 00000000
2 08 1 099 30c30c30
2 0a 1 000 0c3c30c3
f 0b 0 000 00000000

// ==== verilog.f ====
design/led_cube_pkg.sv
design/pattern_select.sv
design/driver_sequencer.sv
design/framebuffer_emulator.sv
design/led_cube_top.sv
verification/led_cube_asserts.sv
verification/led_cube_tb.sv

// ==== Makefile ====
TOP = led_cube_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f verilog.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f verilog.f
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
